// ==== Bender.yml ====
package:
  name: x86_regfile

sources:
  # packages first, then the design bottom up
  - src/x86_arch_pkg.sv
  - src/gpr_impl_pkg.sv
  - src/gpr_read_port.sv
  - src/gpr_subreg_merge.sv
  - src/gpr_write_arbiter.sv
  - src/gpr_array.sv
  - src/x86_regfile_top.sv

  - target: simulation
    files:
      - dv/x86_regfile_checker.sv
      - dv/x86_regfile_tb.sv

// ==== compile.f ====
src/x86_arch_pkg.sv
src/gpr_impl_pkg.sv
src/gpr_read_port.sv
src/gpr_subreg_merge.sv
src/gpr_write_arbiter.sv
src/gpr_array.sv
src/x86_regfile_top.sv
dv/x86_regfile_checker.sv
dv/x86_regfile_tb.sv

// ==== dv/x86_regfile_checker.sv ====
/*
 * register file assertions
 * reset clear, hold without writes and string write latency
 */
`timescale 1ns/1ps

module x86_regfile_checker
    import x86_arch_pkg::*;
    import gpr_impl_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input logic      writeback_en,
    input logic      writeback_2_en,
    input logic      esi_en,
    input logic      edi_en,
    input logic      write_esp_enable,
    input gpr_word_t esi_data,
    input gpr_word_t edi_data,
    input gpr_word_t esi_out,
    input gpr_word_t edi_out,
    input gpr_word_t op_1_value,
    input gpr_word_t op_2_value,
    input gpr_word_t sib_base_value,
    input gpr_word_t sib_index_value,
    input gpr_bank_t bank
);

    int   fail_count = 0;
    logic any_write;

    assign any_write = writeback_en || writeback_2_en || esi_en || edi_en || write_esp_enable;

    reset_clears: assert property (@(posedge clk) rst |=>
        (bank == '0) && (op_1_value == '0) && (op_2_value == '0) &&
        (sib_base_value == '0) && (sib_index_value == '0))
    else begin
        $error("outputs not zero after reset");
        fail_count++;
    end

    // no strobe, no change
    idle_holds: assert property (@(posedge clk) disable iff (rst)
        !any_write |=> bank == $past(bank))
    else begin
        $error("register changed with no write enabled");
        fail_count++;
    end

    esi_loads: assert property (@(posedge clk) disable iff (rst)
        esi_en |=> esi_out == $past(esi_data))
    else begin
        $error("esi not loaded from esi_data");
        fail_count++;
    end

    edi_loads: assert property (@(posedge clk) disable iff (rst)
        edi_en |=> edi_out == $past(edi_data))
    else begin
        $error("edi not loaded from edi_data");
        fail_count++;
    end

endmodule

bind x86_regfile_top x86_regfile_checker x86_regfile_checker_inst (.*);

// ==== dv/x86_regfile_tb.sv ====
/*
 * x86 register file testbench
 * directed tests for reset, full and sub-register writes, dual writeback,
 * string and stack writes, checked against a register model
 */
`timescale 1ns/1ps

module x86_regfile_tb
    import x86_arch_pkg::*;
    import gpr_impl_pkg::*;
();

    localparam int MAX_CYCLES = 2000;

    logic      clk;
    logic      rst;
    reg_size_e register_size;
    reg_size_e writeback_size;
    gpr_code_t op_1, op_2, sib_base_reg, sib_index_reg;
    gpr_code_t writeback_reg, writeback_2_reg;
    logic      writeback_en, writeback_2_en;
    logic      esi_en, edi_en, write_esp_enable;
    gpr_word_t writeback_data, writeback_2_data;
    gpr_word_t esi_data, edi_data, write_esp;
    gpr_word_t op_1_value, op_2_value, sib_base_value, sib_index_value;
    gpr_word_t eax_out, ecx_out, edx_out, ebx_out;
    gpr_word_t esp_out, ebp_out, esi_out, edi_out;

    // expected register contents
    gpr_word_t model [NUM_GPR];
    integer    seed = 19;
    int        cycle_count = 0;

    x86_regfile_top x86_regfile_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
            $display("TESTBENCH FAILED");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    // ----------------------------------------
    // reference model
    // ----------------------------------------

    function automatic gpr_word_t expected_read(gpr_code_t code, reg_size_e size);
        case (size)
            SIZE_32: return model[code];
            SIZE_16: return model[code] & 32'h0000_ffff;
            SIZE_8: begin
                // ah, ch, dh, bh
                if (code >= 4)
                    return (model[code - 4] >> 8) & 32'h0000_00ff;
                return model[code] & 32'h0000_00ff;
            end
            default: return '0;
        endcase
    endfunction

    function automatic void model_write(gpr_code_t code, reg_size_e size, gpr_word_t data);
        case (size)
            SIZE_32: model[code] = data;
            SIZE_16: model[code] = {model[code][31:16], data[15:0]};
            SIZE_8: begin
                if (code >= 4)
                    model[code - 4] = (model[code - 4] & 32'hffff_00ff) | (data[7:0] << 8);
                else
                    model[code] = (model[code] & 32'hffff_ff00) | data[7:0];
            end
            default: ;
        endcase
    endfunction

    // ----------------------------------------
    // compare tasks
    // ----------------------------------------

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_word(string name, gpr_word_t expected, gpr_word_t actual);
        if (actual !== expected) begin
            $display("MISMATCH time=%0t %s expected=%h actual=%h",
                     $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_size_read(string name, gpr_code_t code, reg_size_e size,
                                   gpr_word_t actual);
        gpr_word_t expected;
        expected = expected_read(code, size);
        if (actual !== expected) begin
            $display("MISMATCH time=%0t %s code=%0d size=%s expected=%h actual=%h",
                     $time, name, code, size.name(), expected, actual);
            abort_run();
        end
    endtask

    // ----------------------------------------
    // drive helpers
    // ----------------------------------------

    // next rising edge, all write strobes dropped
    task automatic next_edge();
        @(posedge clk);
        writeback_en     <= 1'b0;
        writeback_2_en   <= 1'b0;
        esi_en           <= 1'b0;
        edi_en           <= 1'b0;
        write_esp_enable <= 1'b0;
    endtask

    task automatic set_wb1(gpr_code_t code, gpr_word_t data);
        writeback_reg  <= code;
        writeback_data <= data;
        writeback_en   <= 1'b1;
    endtask

    task automatic set_wb2(gpr_code_t code, gpr_word_t data);
        writeback_2_reg  <= code;
        writeback_2_data <= data;
        writeback_2_en   <= 1'b1;
    endtask

    // returns just after the edge that loads the register
    task automatic wb_write(gpr_code_t code, reg_size_e size, gpr_word_t data);
        next_edge();
        writeback_size <= size;
        set_wb1(code, data);
        next_edge();
        model_write(code, size, data);
    endtask

    task automatic read_check(gpr_code_t code, reg_size_e size);
        next_edge();
        op_1          <= code;
        op_2          <= code;
        register_size <= size;
        @(negedge clk);
        check_size_read("op_1_value", code, size, op_1_value);
        check_size_read("op_2_value", code, size, op_2_value);
    endtask

    task automatic sib_check(gpr_code_t base, gpr_code_t index);
        next_edge();
        sib_base_reg  <= base;
        sib_index_reg <= index;
        @(negedge clk);
        check_word("sib_base_value", model[base], sib_base_value);
        check_word("sib_index_value", model[index], sib_index_value);
    endtask

    task automatic check_all_regs();
        @(negedge clk);
        check_word("eax_out", model[GPR_EAX], eax_out);
        check_word("ecx_out", model[GPR_ECX], ecx_out);
        check_word("edx_out", model[GPR_EDX], edx_out);
        check_word("ebx_out", model[GPR_EBX], ebx_out);
        check_word("esp_out", model[GPR_ESP], esp_out);
        check_word("ebp_out", model[GPR_EBP], ebp_out);
        check_word("esi_out", model[GPR_ESI], esi_out);
        check_word("edi_out", model[GPR_EDI], edi_out);
    endtask

    // ----------------------------------------
    // tests
    // ----------------------------------------

    task automatic test_reset();
        for (int i = 0; i < NUM_GPR; i++) begin
            read_check(gpr_code_t'(i), SIZE_32);
            sib_check(gpr_code_t'(i), gpr_code_t'(NUM_GPR - 1 - i));
        end
        check_all_regs();
    endtask

    task automatic test_full_width();
        gpr_word_t data;
        for (int i = 0; i < NUM_GPR; i++) begin
            data = $random(seed);
            wb_write(gpr_code_t'(i), SIZE_32, data);
            check_all_regs();
            read_check(gpr_code_t'(i), SIZE_32);
            sib_check(gpr_code_t'(i), gpr_code_t'(NUM_GPR - 1 - i));
        end
    endtask

    task automatic test_subreg();
        gpr_word_t data;
        gpr_word_t stack;
        for (int i = 0; i < NUM_GPR; i++) begin
            data = $random(seed);
            wb_write(gpr_code_t'(i), SIZE_16, data);
            check_all_regs();
            read_check(gpr_code_t'(i), SIZE_16);
        end
        // codes 4 to 7 hit ah..bh here
        for (int i = 0; i < NUM_GPR; i++) begin
            data = $random(seed);
            wb_write(gpr_code_t'(i), SIZE_8, data);
            check_all_regs();
            read_check(gpr_code_t'(i), SIZE_8);
            read_check(gpr_code_t'(i), SIZE_16);
        end
        data = $random(seed);
        wb_write(GPR_EBX, SIZE_RSVD, data);
        check_all_regs();
        read_check(GPR_EBX, SIZE_RSVD);
        // reserved writebacks to esp are dropped, so the stack write lands
        data = $random(seed);
        stack = $random(seed);
        next_edge();
        writeback_size   <= SIZE_RSVD;
        set_wb1(GPR_ESP, data);
        set_wb2(GPR_ESP, data);
        write_esp        <= stack;
        write_esp_enable <= 1'b1;
        next_edge();
        model[GPR_ESP] = stack;
        check_all_regs();
    endtask

    task automatic test_dual_writeback();
        gpr_word_t data_1;
        gpr_word_t data_2;
        data_1 = $random(seed);
        data_2 = $random(seed);
        next_edge();
        writeback_size <= SIZE_32;
        set_wb1(GPR_ECX, data_1);
        set_wb2(GPR_EBX, data_2);
        next_edge();
        model_write(GPR_ECX, SIZE_32, data_1);
        model_write(GPR_EBX, SIZE_32, data_2);
        check_all_regs();
        // same target, port 2 wins
        data_1 = $random(seed);
        data_2 = $random(seed);
        next_edge();
        set_wb1(GPR_EBP, data_1);
        set_wb2(GPR_EBP, data_2);
        next_edge();
        model_write(GPR_EBP, SIZE_32, data_2);
        check_all_regs();
        // back to back, eax then edx
        data_1 = $random(seed);
        data_2 = $random(seed);
        next_edge();
        op_1          <= GPR_EAX;
        op_2          <= GPR_EDX;
        register_size <= SIZE_32;
        set_wb1(GPR_EAX, data_1);
        next_edge();
        model_write(GPR_EAX, SIZE_32, data_1);
        set_wb1(GPR_EDX, data_2);
        @(negedge clk);
        check_size_read("op_1_value", GPR_EAX, SIZE_32, op_1_value);
        check_size_read("op_2_value", GPR_EDX, SIZE_32, op_2_value);
        next_edge();
        model_write(GPR_EDX, SIZE_32, data_2);
        @(negedge clk);
        check_size_read("op_2_value", GPR_EDX, SIZE_32, op_2_value);
    endtask

    task automatic test_string_stack();
        gpr_word_t str_esi;
        gpr_word_t str_edi;
        gpr_word_t wb_a;
        gpr_word_t wb_b;
        gpr_word_t stack;
        str_esi = $random(seed);
        str_edi = $random(seed);
        wb_a = $random(seed);
        wb_b = $random(seed);
        // string writes beat both writeback ports
        next_edge();
        writeback_size <= SIZE_32;
        esi_data       <= str_esi;
        esi_en         <= 1'b1;
        edi_data       <= str_edi;
        edi_en         <= 1'b1;
        set_wb1(GPR_ESI, wb_a);
        set_wb2(GPR_EDI, wb_b);
        next_edge();
        model[GPR_ESI] = str_esi;
        model[GPR_EDI] = str_edi;
        check_all_regs();
        stack = $random(seed);
        next_edge();
        write_esp        <= stack;
        write_esp_enable <= 1'b1;
        next_edge();
        model[GPR_ESP] = stack;
        check_all_regs();
        // writeback to esp beats the stack write
        stack = $random(seed);
        wb_a = $random(seed);
        next_edge();
        write_esp        <= stack;
        write_esp_enable <= 1'b1;
        set_wb1(GPR_ESP, wb_a);
        next_edge();
        model_write(GPR_ESP, SIZE_32, wb_a);
        check_all_regs();
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------

    initial begin
        rst              = 1'b1;
        register_size    = SIZE_32;
        writeback_size   = SIZE_32;
        op_1             = '0;
        op_2             = '0;
        sib_base_reg     = '0;
        sib_index_reg    = '0;
        writeback_reg    = '0;
        writeback_2_reg  = '0;
        writeback_en     = 1'b0;
        writeback_2_en   = 1'b0;
        writeback_data   = '0;
        writeback_2_data = '0;
        esi_en           = 1'b0;
        edi_en           = 1'b0;
        write_esp_enable = 1'b0;
        esi_data         = '0;
        edi_data         = '0;
        write_esp        = '0;
        for (int i = 0; i < NUM_GPR; i++) begin
            model[i] = '0;
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        test_reset();
        test_full_width();
        test_subreg();
        test_dual_writeback();
        test_string_stack();
        next_edge();
        @(negedge clk);
        if (x86_regfile_top_inst.x86_regfile_checker_inst.fail_count == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("assertion failures seen: %0d",
                     x86_regfile_top_inst.x86_regfile_checker_inst.fail_count);
            $display("TESTBENCH FAILED");
            $fatal(1, "assertions failed during the run");
        end
    end

endmodule

// ==== src/gpr_array.sv ====
/*
 * general register array
 * eight 32-bit registers with synchronous clear and per-register load,
 * plus the full-width sib base and index reads
 */
`timescale 1ns/1ps

module gpr_array
    import x86_arch_pkg::*;
    import gpr_impl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  gpr_load_t load,
    input  gpr_bank_t next_bank,
    input  gpr_code_t sib_base_reg,
    input  gpr_code_t sib_index_reg,
    output gpr_bank_t bank,
    output gpr_word_t sib_base_value,
    output gpr_word_t sib_index_value
);

    // ----------------------------------------
    // register storage
    // ----------------------------------------

    // reset wins over any load in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            bank <= '0;
        end else begin
            for (int i = 0; i < NUM_GPR; i++) begin
                if (load[i]) begin
                    bank[i] <= next_bank[i];
                end
            end
        end
    end

    // ----------------------------------------
    // sib address reads
    // ----------------------------------------

    // always full width, no size handling for addressing
    assign sib_base_value  = bank[sib_base_reg];
    assign sib_index_value = bank[sib_index_reg];

endmodule

// ==== src/gpr_impl_pkg.sv ====
/*
 * register file implementation definitions
 * register count, per-register load vector, full bank vector and the
 * write source names used by the write arbiter
 */
package gpr_impl_pkg;

    import x86_arch_pkg::*;

    // ----------------------------------------
    // sizes and vectors
    // ----------------------------------------

    localparam int NUM_GPR = 8;

    // one load strobe per register, indexed by register number
    typedef logic [NUM_GPR-1:0] gpr_load_t;

    // all registers side by side, slot i holds register i
    typedef gpr_word_t [NUM_GPR-1:0] gpr_bank_t;

    // ----------------------------------------
    // write sources
    // ----------------------------------------

    // which requester loads a register this cycle
    typedef enum logic [2:0] {
        SRC_NONE   = 3'd0,
        SRC_WB1    = 3'd1,
        SRC_WB2    = 3'd2,
        SRC_STRING = 3'd3,
        SRC_STACK  = 3'd4
    } wr_src_e;

endpackage

// ==== src/gpr_read_port.sv ====
/*
 * operand read port
 * selects one register by code and returns it at the requested size,
 * zero-extended to a full word
 */
`timescale 1ns/1ps

module gpr_read_port
    import x86_arch_pkg::*;
    import gpr_impl_pkg::*;
(
    input  gpr_code_t reg_code,
    input  reg_size_e size,
    input  gpr_bank_t bank,
    output gpr_word_t value
);

    gpr_code_t phys_code;
    gpr_word_t sel_word;
    logic      high_byte;

    // ----------------------------------------
    // register select
    // ----------------------------------------

    // codes 4 to 7 at byte size mean ah/ch/dh/bh of registers 0 to 3
    assign high_byte = (size == SIZE_8) && reg_code[HIGH_BYTE_CODE_BIT];

    always_comb begin
        phys_code = reg_code;
        if (high_byte) begin
            phys_code[HIGH_BYTE_CODE_BIT] = 1'b0;
        end
    end

    assign sel_word = bank[phys_code];

    // ----------------------------------------
    // size select with zero extension
    // ----------------------------------------

    always_comb begin
        value = '0;
        case (size)
            SIZE_32: begin
                value = sel_word;
            end
            SIZE_16: begin
                value[HALF_BITS-1:0] = sel_word[HALF_BITS-1:0];
            end
            SIZE_8: begin
                if (high_byte) begin
                    value[BYTE_BITS-1:0] = sel_word[2*BYTE_BITS-1:BYTE_BITS];
                end else begin
                    value[BYTE_BITS-1:0] = sel_word[BYTE_BITS-1:0];
                end
            end
            // reserved size reads as zero
            default: begin
                value = '0;
            end
        endcase
    end

endmodule

// ==== src/gpr_subreg_merge.sv ====
/*
 * writeback sub-register merge
 * maps the writeback code to its physical register and folds the new
 * data into the old contents at the writeback size
 */
`timescale 1ns/1ps

module gpr_subreg_merge
    import x86_arch_pkg::*;
    import gpr_impl_pkg::*;
(
    input  gpr_code_t reg_code,
    input  reg_size_e size,
    input  gpr_word_t data,
    input  gpr_bank_t bank,
    output gpr_code_t target,
    output gpr_word_t merged,
    output logic      size_valid
);

    gpr_word_t old_word;
    logic      high_byte;

    // ----------------------------------------
    // physical target
    // ----------------------------------------

    assign high_byte = (size == SIZE_8) && reg_code[HIGH_BYTE_CODE_BIT];

    always_comb begin
        target = reg_code;
        if (high_byte) begin
            // ah..bh live in bits 15:8 of eax..ebx
            target[HIGH_BYTE_CODE_BIT] = 1'b0;
        end
    end

    assign old_word = bank[target];

    // reserved size must never reach a register
    assign size_valid = (size != SIZE_RSVD);

    // ----------------------------------------
    // merge
    // ----------------------------------------

    always_comb begin
        merged = old_word;
        case (size)
            SIZE_32: begin
                merged = data;
            end
            SIZE_16: begin
                merged[HALF_BITS-1:0] = data[HALF_BITS-1:0];
            end
            SIZE_8: begin
                if (high_byte) begin
                    merged[2*BYTE_BITS-1:BYTE_BITS] = data[BYTE_BITS-1:0];
                end else begin
                    merged[BYTE_BITS-1:0] = data[BYTE_BITS-1:0];
                end
            end
            default: begin
                // old contents, blocked by size_valid anyway
                merged = old_word;
            end
        endcase
    end

endmodule

// ==== src/gpr_write_arbiter.sv ====
/*
 * register file write arbiter
 * per register, picks one of the writeback, string or stack writes and
 * drives the load strobe and next value for that register
 */
`timescale 1ns/1ps

module gpr_write_arbiter
    import x86_arch_pkg::*;
    import gpr_impl_pkg::*;
(
    input  logic      wb_en,
    input  gpr_code_t wb_target,
    input  gpr_word_t wb_merged,
    input  logic      wb_valid,
    input  logic      wb2_en,
    input  gpr_code_t wb2_target,
    input  gpr_word_t wb2_merged,
    input  logic      wb2_valid,
    input  logic      esi_en,
    input  gpr_word_t esi_data,
    input  logic      edi_en,
    input  gpr_word_t edi_data,
    input  logic      write_esp_enable,
    input  gpr_word_t write_esp,
    output gpr_load_t load,
    output gpr_bank_t next_bank
);

    gpr_load_t wb1_req;
    gpr_load_t wb2_req;
    gpr_load_t str_req;
    gpr_load_t stk_req;
    wr_src_e   grant [NUM_GPR];

    // ----------------------------------------
    // request decode
    // ----------------------------------------

    // a writeback counts only with a legal size
    assign wb1_req = (wb_en && wb_valid) ? (gpr_load_t'(1) << wb_target) : '0;
    assign wb2_req = (wb2_en && wb2_valid) ? (gpr_load_t'(1) << wb2_target) : '0;

    always_comb begin
        str_req = '0;
        str_req[GPR_ESI] = esi_en;
        str_req[GPR_EDI] = edi_en;
    end

    always_comb begin
        stk_req = '0;
        stk_req[GPR_ESP] = write_esp_enable;
    end

    // ----------------------------------------
    // per-register grant
    // ----------------------------------------

    // string > wb2 > wb1 > stack
    always_comb begin
        for (int i = 0; i < NUM_GPR; i++) begin
            if (str_req[i]) begin
                grant[i] = SRC_STRING;
            end else if (wb2_req[i]) begin
                grant[i] = SRC_WB2;
            end else if (wb1_req[i]) begin
                grant[i] = SRC_WB1;
            end else if (stk_req[i]) begin
                grant[i] = SRC_STACK;
            end else begin
                grant[i] = SRC_NONE;
            end
        end
    end

    // ----------------------------------------
    // load strobes and data steering
    // ----------------------------------------

    always_comb begin
        for (int i = 0; i < NUM_GPR; i++) begin
            load[i] = (grant[i] != SRC_NONE);
            case (grant[i])
                SRC_WB1:    next_bank[i] = wb_merged;
                SRC_WB2:    next_bank[i] = wb2_merged;
                SRC_STRING: next_bank[i] = (i == GPR_ESI) ? esi_data : edi_data;
                SRC_STACK:  next_bank[i] = write_esp;
                default:    next_bank[i] = '0;
            endcase
        end
    end

endmodule

// ==== src/x86_arch_pkg.sv ====
/*
 * x86 architectural definitions
 * register value, register code and operand size types, plus the
 * register numbers used by the instruction encoding
 */
package x86_arch_pkg;

    // ----------------------------------------
    // basic types
    // ----------------------------------------

    // one general register
    typedef logic [31:0] gpr_word_t;

    // register field from modrm, sib or opcode
    typedef logic [2:0] gpr_code_t;

    // operand size, shared by reads and writebacks
    typedef enum logic [1:0] {
        SIZE_32   = 2'b00,
        SIZE_16   = 2'b01,
        SIZE_8    = 2'b10,
        SIZE_RSVD = 2'b11
    } reg_size_e;

    // ----------------------------------------
    // register numbers
    // ----------------------------------------

    localparam gpr_code_t GPR_EAX = 3'd0;
    localparam gpr_code_t GPR_ECX = 3'd1;
    localparam gpr_code_t GPR_EDX = 3'd2;
    localparam gpr_code_t GPR_EBX = 3'd3;
    localparam gpr_code_t GPR_ESP = 3'd4;
    localparam gpr_code_t GPR_EBP = 3'd5;
    localparam gpr_code_t GPR_ESI = 3'd6;
    localparam gpr_code_t GPR_EDI = 3'd7;

    // sub-register widths
    localparam int HALF_BITS = 16;
    localparam int BYTE_BITS = 8;

    // at 8-bit size this code bit picks ah/ch/dh/bh over al/cl/dl/bl
    localparam int HIGH_BYTE_CODE_BIT = 2;

endpackage

// ==== src/x86_regfile_top.sv ====
/*
 * x86 integer register file
 * two sized operand reads, two sib reads, two merged writebacks,
 * string and stack writes, and all eight registers as outputs
 */
`timescale 1ns/1ps

module x86_regfile_top
    import x86_arch_pkg::*;
    import gpr_impl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  reg_size_e register_size,
    input  reg_size_e writeback_size,
    input  gpr_code_t op_1,
    input  gpr_code_t op_2,
    input  gpr_code_t sib_base_reg,
    input  gpr_code_t sib_index_reg,
    output gpr_word_t op_1_value,
    output gpr_word_t op_2_value,
    output gpr_word_t sib_base_value,
    output gpr_word_t sib_index_value,
    input  gpr_code_t writeback_reg,
    input  gpr_code_t writeback_2_reg,
    input  logic      writeback_en,
    input  logic      writeback_2_en,
    input  gpr_word_t writeback_data,
    input  gpr_word_t writeback_2_data,
    input  gpr_word_t esi_data,
    input  gpr_word_t edi_data,
    input  gpr_word_t write_esp,
    input  logic      esi_en,
    input  logic      edi_en,
    input  logic      write_esp_enable,
    output gpr_word_t eax_out,
    output gpr_word_t ecx_out,
    output gpr_word_t edx_out,
    output gpr_word_t ebx_out,
    output gpr_word_t esp_out,
    output gpr_word_t ebp_out,
    output gpr_word_t esi_out,
    output gpr_word_t edi_out
);

    gpr_bank_t bank;
    gpr_bank_t next_bank;
    gpr_load_t load;
    gpr_code_t wb1_target;
    gpr_code_t wb2_target;
    gpr_word_t wb1_merged;
    gpr_word_t wb2_merged;
    logic      wb1_valid;
    logic      wb2_valid;

    // ----------------------------------------
    // operand reads
    // ----------------------------------------

    gpr_read_port op_1_read (
        .reg_code (op_1),
        .size     (register_size),
        .bank     (bank),
        .value    (op_1_value)
    );

    gpr_read_port op_2_read (
        .reg_code (op_2),
        .size     (register_size),
        .bank     (bank),
        .value    (op_2_value)
    );

    // ----------------------------------------
    // writeback merge, size shared by both
    // ----------------------------------------

    gpr_subreg_merge wb1_merge (
        .reg_code   (writeback_reg),
        .size       (writeback_size),
        .data       (writeback_data),
        .bank       (bank),
        .target     (wb1_target),
        .merged     (wb1_merged),
        .size_valid (wb1_valid)
    );

    gpr_subreg_merge wb2_merge (
        .reg_code   (writeback_2_reg),
        .size       (writeback_size),
        .data       (writeback_2_data),
        .bank       (bank),
        .target     (wb2_target),
        .merged     (wb2_merged),
        .size_valid (wb2_valid)
    );

    // ----------------------------------------
    // arbiter and storage
    // ----------------------------------------

    gpr_write_arbiter write_arb (
        .wb_en            (writeback_en),
        .wb_target        (wb1_target),
        .wb_merged        (wb1_merged),
        .wb_valid         (wb1_valid),
        .wb2_en           (writeback_2_en),
        .wb2_target       (wb2_target),
        .wb2_merged       (wb2_merged),
        .wb2_valid        (wb2_valid),
        .esi_en           (esi_en),
        .esi_data         (esi_data),
        .edi_en           (edi_en),
        .edi_data         (edi_data),
        .write_esp_enable (write_esp_enable),
        .write_esp        (write_esp),
        .load             (load),
        .next_bank        (next_bank)
    );

    gpr_array regs (
        .clk             (clk),
        .rst             (rst),
        .load            (load),
        .next_bank       (next_bank),
        .sib_base_reg    (sib_base_reg),
        .sib_index_reg   (sib_index_reg),
        .bank            (bank),
        .sib_base_value  (sib_base_value),
        .sib_index_value (sib_index_value)
    );

    // named register outputs
    assign eax_out = bank[GPR_EAX];
    assign ecx_out = bank[GPR_ECX];
    assign edx_out = bank[GPR_EDX];
    assign ebx_out = bank[GPR_EBX];
    assign esp_out = bank[GPR_ESP];
    assign ebp_out = bank[GPR_EBP];
    assign esi_out = bank[GPR_ESI];
    assign edi_out = bank[GPR_EDI];

endmodule
